// ==== source/fetch_pkg.sv ====
/* Shared widths, opcodes and the instruction word views of the fetch front end.
   RV32 only. Compressed fields assume the halfword sits in bits 15:0 of the word */

`default_nettype none

package fetch_pkg;

  // Address and data width
  localparam int unsigned xlen = 32;

  // Major opcodes of uncompressed control transfers
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;

  // Compressed quadrant holding C.J, C.JAL, C.BEQZ and C.BNEZ
  localparam logic [1:0] c_quadrant_1 = 2'b01;

  // Compressed funct3 codes in quadrant 1
  localparam logic [2:0] c_funct3_jal  = 3'b001;
  localparam logic [2:0] c_funct3_j    = 3'b101;
  localparam logic [2:0] c_funct3_beqz = 3'b110;
  localparam logic [2:0] c_funct3_bnez = 3'b111;

  // One fetched word, read either as a full 32-bit instruction or as a halfword
  typedef union packed {
    // Uncompressed R/B/J field layout
    struct packed {
      // Bits 31:25, holds the upper immediate bits of B and J types
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      // Bits 11:7, low immediate bits of a B type
      logic [4:0] rd;
      logic [6:0] opcode;
    } base;
    // Compressed CB layout, CJ reuses the same bits as one offset
    struct packed {
      // Next halfword, not part of a compressed instruction
      logic [15:0] hi_half;
      logic [2:0]  funct3;
      // Bits 12:10
      logic [2:0]  off_hi;
      // Bits 9:7, rs1' in CB and offset in CJ
      logic [2:0]  rs1p;
      // Bits 6:2
      logic [4:0]  off_lo;
      logic [1:0]  op;
    } comp;
  } instr_word_t;

endpackage

`default_nettype wire

// ==== source/fetch_if.sv ====
/* Fetched word and its static prediction between PC generator and predictor.
   rdata is driven by the top level straight from instruction memory */

`default_nettype none

interface fetch_if import fetch_pkg::*; ();

  // Current fetch address
  logic [xlen-1:0] pc;
  // Word returned by memory for pc, same cycle
  logic [xlen-1:0] rdata;
  // Out of reset and not stalled
  logic            valid;

  // Prediction for the word in rdata
  logic            predict_taken;
  logic [xlen-1:0] predict_pc;

  // PC generator side
  modport gen (
    output pc,
    output valid,
    input  rdata,
    input  predict_taken,
    input  predict_pc
  );

  // Predictor side
  modport pred (
    input  pc,
    input  rdata,
    input  valid,
    output predict_taken,
    output predict_pc
  );

endinterface

`default_nettype wire

// ==== source/branch_predict.sv ====
/* Static predictor, purely combinational with zero latency.
   Jumps always taken, branches taken on negative offset. JALR and C.JR/C.JALR are
   not recognized. A compressed word must sit in the low halfword of rdata */

`default_nettype none

module branch_predict import fetch_pkg::*; (
  fetch_if.pred fetch_i
);

  // Word seen through both decode views
  instr_word_t     instr;

  // Sign-extended offsets per format
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_cj;
  logic [xlen-1:0] imm_cb;

  // Offset picked by the decoded kind
  logic [xlen-1:0] branch_imm;

  // One-hot kind, {jal, branch, c.j/c.jal, c.beqz/c.bnez}
  logic            instr_j;
  logic            instr_b;
  logic            instr_cj;
  logic            instr_cb;
  logic [3:0]      kind;

  // Conditional branch predicted backward
  logic            b_taken;

  assign instr = fetch_i.rdata;

  // JAL offset
  // imm[20|10:1|11|19:12] sits in bits 31:12
  assign imm_j = {{12{instr.base.imm_hi[6]}},
                  instr.base.rs1,
                  instr.base.funct3,
                  instr.base.rs2[0],
                  instr.base.imm_hi[5:0],
                  instr.base.rs2[4:1],
                  1'b0};

  // B-type offset
  // imm[12|10:5] in bits 31:25, imm[4:1|11] in bits 11:7
  assign imm_b = {{19{instr.base.imm_hi[6]}},
                  instr.base.imm_hi[6],
                  instr.base.rd[0],
                  instr.base.imm_hi[5:0],
                  instr.base.rd[4:1],
                  1'b0};

  // CJ offset
  // Bit order 11|4|9:8|10|6|7|3:1|5 across bits 12:2
  assign imm_cj = {{20{instr.comp.off_hi[2]}},
                   instr.comp.off_hi[2],
                   instr.comp.rs1p[1],
                   instr.comp.off_hi[0],
                   instr.comp.rs1p[2],
                   instr.comp.off_lo[4],
                   instr.comp.rs1p[0],
                   instr.comp.off_lo[0],
                   instr.comp.off_hi[1],
                   instr.comp.off_lo[3:1],
                   1'b0};

  // CB offset
  // Bits 12:10 give 8|4:3, bits 6:2 give 7:6|2:1|5
  assign imm_cb = {{23{instr.comp.off_hi[2]}},
                   instr.comp.off_hi[2],
                   instr.comp.off_lo[4:3],
                   instr.comp.off_lo[0],
                   instr.comp.off_hi[1:0],
                   instr.comp.off_lo[2:1],
                   1'b0};

  // Uncompressed kinds
  // Full opcode includes bits 1:0 == 2'b11, so never overlaps a compressed kind
  assign instr_b = (instr.base.opcode == opc_branch);
  assign instr_j = (instr.base.opcode == opc_jal);

  // Compressed kinds, quadrant 1 only
  assign instr_cb = (instr.comp.op == c_quadrant_1) &
                    ((instr.comp.funct3 == c_funct3_beqz) |
                     (instr.comp.funct3 == c_funct3_bnez));
  assign instr_cj = (instr.comp.op == c_quadrant_1) &
                    ((instr.comp.funct3 == c_funct3_j) |
                     (instr.comp.funct3 == c_funct3_jal));

  assign kind = {instr_j, instr_b, instr_cj, instr_cb};

  // Offset mux
  always_comb begin
    branch_imm = '0;
    unique case (kind)
      4'b1000: branch_imm = imm_j;
      4'b0100: branch_imm = imm_b;
      4'b0010: branch_imm = imm_cj;
      4'b0001: branch_imm = imm_cb;
      // Not a control transfer, target unused
      default: branch_imm = '0;
    endcase
  end

  // Backward branch, sign of the selected offset
  assign b_taken = (instr_b | instr_cb) & branch_imm[xlen-1];

  // Jumps always taken
  assign fetch_i.predict_taken = fetch_i.valid & (instr_j | instr_cj | b_taken);

  // PC-relative target
  assign fetch_i.predict_pc = fetch_i.pc + branch_imm;

endmodule

`default_nettype wire

// ==== source/fetch_pc_gen.sv ====
/* Fetch PC register. Memory must answer in the same cycle as the address.
   Priority is redirect, stall, predicted target, then sequential +2/+4.
   Redirect targets are taken as given, no alignment check */

`default_nettype none

module fetch_pc_gen import fetch_pkg::*; #(
  parameter logic [xlen-1:0] BOOT_ADDR = 32'h0000_1000
) (
  input  logic            clk_i,
  input  logic            rst_n_i,

  // Back-pressure from decode
  input  logic            stall_i,

  // Later-stage correction, e.g. resolved mispredict
  input  logic            redirect_i,
  input  logic [xlen-1:0] redirect_pc_i,

  // Fetch address out, word and prediction back
  fetch_if.gen            fetch_o
);

  // Current and next fetch address
  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] pc_d;

  // Instruction length of the fetched word
  logic            is_compressed;
  logic [xlen-1:0] pc_step;

  // Sequential successor of pc_q
  logic [xlen-1:0] pc_seq;

  // Low bits 2'b11 mark a 32-bit instruction
  assign is_compressed = (fetch_o.rdata[1:0] != 2'b11);

  // Step 2 for a halfword, 4 for a full word
  assign pc_step = is_compressed ? xlen'(2) : xlen'(4);

  assign pc_seq = pc_q + pc_step;

  // Next PC selection
  always_comb begin
    if (redirect_i) begin
      // Redirect wins over everything else
      pc_d = redirect_pc_i;
    end else if (stall_i) begin
      // Hold while decode is busy
      pc_d = pc_q;
    end else if (fetch_o.predict_taken) begin
      // Follow the static prediction
      pc_d = fetch_o.predict_pc;
    end else begin
      pc_d = pc_seq;
    end
  end

  // PC register
  // Boot address loaded on every reset cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q <= BOOT_ADDR;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign fetch_o.pc = pc_q;

  // Word at pc_q is usable only out of reset and not stalled
  // Also gates predict_taken inside the predictor
  assign fetch_o.valid = rst_n_i & ~stall_i;

endmodule

`default_nettype wire

// ==== source/fetch_top.sv ====
/* Fetch front end with static branch prediction, RV32 with compressed support.
   External instruction memory returns the whole instruction at any halfword
   address in the same cycle. JALR-type jumps are not predicted */

`default_nettype none

module fetch_top import fetch_pkg::*; #(
  parameter logic [xlen-1:0] BOOT_ADDR = 32'h0000_1000
) (
  input  logic            clk_i,
  input  logic            rst_n_i,

  // Pipeline control
  input  logic            stall_i,
  input  logic            redirect_i,
  input  logic [xlen-1:0] redirect_pc_i,

  // Instruction memory, zero latency
  output logic [xlen-1:0] imem_addr_o,
  input  logic [xlen-1:0] imem_rdata_i,

  // Fetched instruction to decode
  output logic [xlen-1:0] fetch_pc_o,
  output logic [xlen-1:0] fetch_instr_o,
  output logic            fetch_valid_o,

  // Static prediction for the fetched instruction
  output logic            predict_taken_o,
  output logic [xlen-1:0] predict_pc_o
);

  // Shared fetch bundle
  fetch_if fetch_bus ();

  // Memory word goes straight onto the bundle
  assign fetch_bus.rdata = imem_rdata_i;

  // PC register and next-PC selection
  fetch_pc_gen #(
    .BOOT_ADDR     (BOOT_ADDR)
  ) u_fetch_pc_gen (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .fetch_o       (fetch_bus)
  );

  // Decode and target calculation
  branch_predict u_branch_predict (
    .fetch_i (fetch_bus)
  );

  // Memory address is the current PC
  assign imem_addr_o     = fetch_bus.pc;

  // Outputs to decode
  assign fetch_pc_o      = fetch_bus.pc;
  assign fetch_instr_o   = fetch_bus.rdata;
  assign fetch_valid_o   = fetch_bus.valid;
  assign predict_taken_o = fetch_bus.predict_taken;
  assign predict_pc_o    = fetch_bus.predict_pc;

endmodule

`default_nettype wire

// ==== verif/fetch_checker.sv ====
/* Compares fetch_top ports with the reference prediction from the testbench.
   Samples on the falling edge, inputs change only on the rising edge */

`default_nettype none

module fetch_checker #(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_1000
) (
  input  logic        clk_i,
  input  logic        rst_n_i,

  // DUT inputs as driven
  input  logic        stall_i,
  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i,

  // DUT outputs
  input  logic [31:0] imem_addr_i,
  input  logic [31:0] fetch_pc_i,
  input  logic [31:0] fetch_instr_i,
  input  logic        fetch_valid_i,
  input  logic        predict_taken_i,
  input  logic [31:0] predict_pc_i,

  // Memory word and reference result at fetch_pc_i
  input  logic [31:0] exp_word_i,
  input  logic [2:0]  ref_kind_i,
  input  logic        ref_taken_i,
  input  logic [31:0] ref_target_i,
  input  logic [31:0] ref_seq_i,

  output int          pc_errs_o,
  output int          pred_errs_o,
  output int          port_errs_o,
  // Two bins per kind, positive then negative offset
  output logic [11:0] seen_o
);

  int          pc_errs   = 0;
  int          pred_errs = 0;
  int          port_errs = 0;
  logic [11:0] seen      = '0;

  // PC expected after the last edge
  logic [31:0] exp_pc    = BOOT_ADDR;
  logic        have_exp  = 1'b0;

  assign pc_errs_o   = pc_errs;
  assign pred_errs_o = pred_errs;
  assign port_errs_o = port_errs;
  assign seen_o      = seen;

  task automatic report_mismatch(input string msg);
    $display("ERR %0t: %s", $time, msg);
  endtask

  always @(negedge clk_i) begin : compare
    logic        exp_valid;
    logic        exp_taken;
    logic [31:0] offset;
    int          cov_bin;
    exp_valid = rst_n_i & ~stall_i;
    exp_taken = exp_valid & ref_taken_i;
    offset    = ref_target_i - fetch_pc_i;

    // PC follows from the previous cycle
    if (have_exp && fetch_pc_i !== exp_pc) begin
      report_mismatch($sformatf("fetch_pc %h, expected %h", fetch_pc_i, exp_pc));
      pc_errs++;
    end

    // Memory port and pass-through
    if (imem_addr_i !== fetch_pc_i) begin
      report_mismatch($sformatf("imem_addr %h differs from fetch_pc %h",
                                imem_addr_i, fetch_pc_i));
      port_errs++;
    end
    if (fetch_instr_i !== exp_word_i) begin
      report_mismatch($sformatf("fetch_instr %h, memory holds %h", fetch_instr_i, exp_word_i));
      port_errs++;
    end
    if (fetch_valid_i !== exp_valid) begin
      report_mismatch($sformatf("fetch_valid %b, expected %b", fetch_valid_i, exp_valid));
      port_errs++;
    end

    // Prediction, target only for a control transfer
    if (predict_taken_i !== exp_taken) begin
      report_mismatch($sformatf("predict_taken %b, expected %b for word %h at %h",
                                predict_taken_i, exp_taken, exp_word_i, fetch_pc_i));
      pred_errs++;
    end
    if (exp_valid && ref_kind_i != 3'd0 && predict_pc_i !== ref_target_i) begin
      report_mismatch($sformatf("predict_pc %h, expected %h for word %h",
                                predict_pc_i, ref_target_i, exp_word_i));
      pred_errs++;
    end

    if (exp_valid && ref_kind_i != 3'd0) begin
      cov_bin = (int'(ref_kind_i) - 1) * 2 + int'(offset[31]);
      seen[cov_bin] = 1'b1;
    end

    // Next PC by priority
    if (!rst_n_i)
      exp_pc = BOOT_ADDR;
    else if (redirect_i)
      exp_pc = redirect_pc_i;
    else if (stall_i)
      exp_pc = fetch_pc_i;
    else if (exp_taken)
      exp_pc = ref_target_i;
    else
      exp_pc = ref_seq_i;
    have_exp = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verif/tb_fetch_top.sv ====
/* Testbench for fetch_top. 4 KB halfword memory mapped at the boot address and
   wrapped, filled from an LFSR with planted jumps and branches. Random stall/redirect */

`default_nettype none

module tb_fetch_top;

  localparam logic [31:0] boot_addr    = 32'h0000_1000;
  localparam int          mem_halves   = 2048;
  localparam int          reset_cycles = 16;
  localparam int          test_cycles  = 4000;
  // Full run plus margin
  localparam int          cycle_limit  = reset_cycles + test_cycles + 200;

  // DUT inputs
  logic        clk = 1'b0;
  logic        rst_n;
  logic        stall;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic [31:0] imem_rdata;

  // DUT outputs
  logic [31:0] imem_addr;
  logic [31:0] fetch_pc;
  logic [31:0] fetch_instr;
  logic        fetch_valid;
  logic        predict_taken;
  logic [31:0] predict_pc;

  // Memory model
  logic [15:0] mem [mem_halves];
  logic [10:0] addr_idx;
  logic [10:0] addr_idx_nx;
  logic [10:0] pc_idx;
  logic [10:0] pc_idx_nx;
  logic [31:0] exp_word;

  // Reference outputs for the current fetch
  logic [2:0]  ref_kind;
  logic        ref_taken;
  logic [31:0] ref_target;
  logic [31:0] ref_seq;

  // Checker results
  int          pc_errs;
  int          pred_errs;
  int          port_errs;
  logic [11:0] seen;

  logic [15:0] lfsr_state = 16'd45756;
  int          cycle_count = 0;

  always #4 clk = ~clk;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    int          i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      if (lfsr_state[0])
        lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
      else
        lfsr_state = lfsr_state >> 1;
    end
    return bits;
  endfunction

  // Nonzero even offset of up to nbits+1 magnitude bits, random sign
  function automatic logic [31:0] rand_offset(input int nbits);
    logic [31:0] off;
    off = (take_bits(nbits) | 32'd1) << 1;
    if (take_bits(1) != 0)
      off = -off;
    return off;
  endfunction

  // Instruction encoders for planting
  function automatic logic [31:0] encode_jal(input logic [31:0] off);
    logic [4:0] rd;
    rd = 5'(take_bits(5));
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6F};
  endfunction

  function automatic logic [31:0] encode_branch(input logic [31:0] off);
    logic [14:0] regs;
    regs = 15'(take_bits(15));
    return {off[12], off[10:5], regs[14:5], regs[2:0], off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [15:0] encode_cj(input logic [2:0] f3, input logic [31:0] off);
    return {f3, off[11], off[4], off[9:8], off[10], off[6], off[7], off[3:1], off[5], 2'b01};
  endfunction

  function automatic logic [15:0] encode_cb(input logic [2:0] f3, input logic [31:0] off);
    logic [2:0] rs1p;
    rs1p = 3'(take_bits(3));
    return {f3, off[8], off[4:3], rs1p, off[7:6], off[2:1], off[5], 2'b01};
  endfunction

  // Expected prediction by the decode rules
  // Kinds: 0 none, 1 JAL, 2 branch, 3 C.J, 4 C.JAL, 5 C.BEQZ, 6 C.BNEZ
  function automatic void ref_predict(input logic [31:0] pc, input logic [31:0] w,
                                      output logic [2:0] kind, output logic taken,
                                      output logic [31:0] target, output logic [31:0] seq);
    logic [31:0] off;
    off = '0;
    kind = 3'd0;
    if (w[6:0] == 7'h6F) begin
      kind = 3'd1;
      off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    end else if (w[6:0] == 7'h63) begin
      kind = 3'd2;
      off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    end else if (w[1:0] == 2'b01 && (w[15:13] == 3'b101 || w[15:13] == 3'b001)) begin
      kind = (w[15:13] == 3'b101) ? 3'd3 : 3'd4;
      off = {{20{w[12]}}, w[12], w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
    end else if (w[1:0] == 2'b01 && (w[15:13] == 3'b110 || w[15:13] == 3'b111)) begin
      kind = (w[15:13] == 3'b110) ? 3'd5 : 3'd6;
      off = {{23{w[12]}}, w[12], w[6:5], w[2], w[11:10], w[4:3], 1'b0};
    end
    // Jumps always, conditional branches only backward
    taken = (kind == 3'd1 || kind == 3'd3 || kind == 3'd4) ||
            ((kind == 3'd2 || kind == 3'd5 || kind == 3'd6) && off[31]);
    target = pc + off;
    seq = pc + ((w[1:0] == 2'b11) ? 32'd4 : 32'd2);
  endfunction

  function automatic string kind_name(input int kind);
    case (kind)
      1:       return "JAL";
      2:       return "B-type";
      3:       return "C.J";
      4:       return "C.JAL";
      5:       return "C.BEQZ";
      default: return "C.BNEZ";
    endcase
  endfunction

  // Random fill mixed with the halfword index
  task automatic fill_memory();
    int i;
    for (i = 0; i < mem_halves; i++)
      mem[i] = 16'(take_bits(16)) ^ 16'(i);
  endtask

  // Roughly one in four halfwords starts a planted control transfer
  task automatic plant_instructions();
    int          i;
    int          pick;
    logic [31:0] word;
    i = 0;
    while (i < mem_halves) begin
      if (take_bits(2) == 0) begin
        pick = take_bits(3) % 6;
        case (pick)
          0:       word = encode_jal(rand_offset(10));
          1:       word = encode_branch(rand_offset(10));
          2:       word = {16'h0, encode_cj(3'b101, rand_offset(10))};
          3:       word = {16'h0, encode_cj(3'b001, rand_offset(10))};
          4:       word = {16'h0, encode_cb(3'b110, rand_offset(7))};
          default: word = {16'h0, encode_cb(3'b111, rand_offset(7))};
        endcase
        mem[i] = word[15:0];
        if (pick < 2) begin
          mem[(i + 1) % mem_halves] = word[31:16];
          i += 2;
        end else begin
          i += 1;
        end
      end else begin
        i += 1;
      end
    end
  endtask

  // Zero-latency memory, whole instruction at any halfword
  assign addr_idx    = imem_addr[11:1];
  assign addr_idx_nx = addr_idx + 11'd1;
  assign imem_rdata  = {mem[addr_idx_nx], mem[addr_idx]};

  // Independent read at the fetch PC for the checker
  assign pc_idx    = fetch_pc[11:1];
  assign pc_idx_nx = pc_idx + 11'd1;
  assign exp_word  = {mem[pc_idx_nx], mem[pc_idx]};

  always_comb begin
    ref_predict(fetch_pc, exp_word, ref_kind, ref_taken, ref_target, ref_seq);
  end

  fetch_top #(
    .BOOT_ADDR       (boot_addr)
  ) u_fetch_top (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .stall_i         (stall),
    .redirect_i      (redirect),
    .redirect_pc_i   (redirect_pc),
    .imem_addr_o     (imem_addr),
    .imem_rdata_i    (imem_rdata),
    .fetch_pc_o      (fetch_pc),
    .fetch_instr_o   (fetch_instr),
    .fetch_valid_o   (fetch_valid),
    .predict_taken_o (predict_taken),
    .predict_pc_o    (predict_pc)
  );

  fetch_checker #(
    .BOOT_ADDR       (boot_addr)
  ) u_fetch_checker (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .stall_i         (stall),
    .redirect_i      (redirect),
    .redirect_pc_i   (redirect_pc),
    .imem_addr_i     (imem_addr),
    .fetch_pc_i      (fetch_pc),
    .fetch_instr_i   (fetch_instr),
    .fetch_valid_i   (fetch_valid),
    .predict_taken_i (predict_taken),
    .predict_pc_i    (predict_pc),
    .exp_word_i      (exp_word),
    .ref_kind_i      (ref_kind),
    .ref_taken_i     (ref_taken),
    .ref_target_i    (ref_target),
    .ref_seq_i       (ref_seq),
    .pc_errs_o       (pc_errs),
    .pred_errs_o     (pred_errs),
    .port_errs_o     (port_errs),
    .seen_o          (seen)
  );

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run did not end within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  initial begin : stimulus
    int cyc;
    int k;
    int cov_errs;
    rst_n       <= 1'b0;
    stall       <= 1'b0;
    redirect    <= 1'b0;
    redirect_pc <= boot_addr;
    fill_memory();
    plant_instructions();
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    for (cyc = 0; cyc < test_cycles; cyc++) begin
      @(posedge clk);
      stall       <= (take_bits(3) == 0);
      redirect    <= (take_bits(4) == 0);
      redirect_pc <= boot_addr + (take_bits(11) << 1);
    end
    @(posedge clk);
    stall    <= 1'b0;
    redirect <= 1'b0;
    // Last compare happens on this falling edge, counts settle before the next rise
    @(negedge clk);
    @(posedge clk);
    // Every kind seen with both offset signs
    cov_errs = 0;
    for (k = 0; k < 12; k++) begin
      if (!seen[k]) begin
        $display("coverage: no valid fetch of %s with a %s offset",
                 kind_name(k / 2 + 1), (k % 2 != 0) ? "negative" : "positive");
        cov_errs++;
      end
    end
    $display("error counts: pc %0d, predict %0d, port %0d, coverage %0d",
             pc_errs, pred_errs, port_errs, cov_errs);
    if (pc_errs + pred_errs + port_errs + cov_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
source/fetch_pkg.sv
source/fetch_if.sv
source/branch_predict.sv
source/fetch_pc_gen.sv
source/fetch_top.sv
verif/fetch_checker.sv
verif/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_top

sources:
  - files:
      - source/fetch_pkg.sv
      - source/fetch_if.sv
      - source/branch_predict.sv
      - source/fetch_pc_gen.sv
      - source/fetch_top.sv
  - target: test
    files:
      - verif/fetch_checker.sv
      - verif/tb_fetch_top.sv
